/* build.f */
design/ram_pkg.sv
design/bank_port_if.sv
design/ram_bank.sv
design/bank_access.sv
design/read_merge.sv
design/mpram_top.sv
test/mpram_checker.sv
test/mpram_properties.sv
test/mpram_tb.sv

/* design/bank_access.sv */
`timescale 1ns/10ps

module bank_access import ram_pkg::*; #(
    parameter word_t RESET_VALUE = '0
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [READ_PORTS-1:0]      en,
    input  mem_addr_t [READ_PORTS-1:0] raddr,
    input  strobe_t                    we,
    input  mem_addr_t                  waddr,
    input  word_t                      wdata,
    output logic                       ready,
    bank_port_if.access                bank0,
    bank_port_if.access                bank1
);

    logic [ROW_WIDTH:0]    sweep_cnt;     // Top bit set once every row is done
    logic                  sweeping;
    row_t [READ_PORTS-1:0] rd_row;
    row_t                  wr_row;
    word_t                 wr_data;

    function automatic logic [READ_PORTS-1:0] read_enables(
        input logic [BANK_WIDTH-1:0]      sel,
        input logic [READ_PORTS-1:0]      req,
        input logic                       open,
        input mem_addr_t [READ_PORTS-1:0] addr
    );
        logic [READ_PORTS-1:0] hit;
        for (int p = 0; p < READ_PORTS; p++) begin
            hit[p] = req[p] && open && (addr[p].split.bank == sel);
        end
        return hit;
    endfunction

    function automatic strobe_t write_strobes(
        input logic [BANK_WIDTH-1:0] sel,
        input logic                  sweep,
        input logic                  open,
        input strobe_t               mask,
        input mem_addr_t             addr
    );
        if (sweep) begin
            return '1;                       // Sweep fills whole rows
        end
        if (open && addr.split.bank == sel) begin
            return mask;
        end
        return '0;
    endfunction

    assign sweeping = !ready && !sweep_cnt[ROW_WIDTH];

    // Counts through every row, then opens the ports one cycle later
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sweep_cnt <= '0;
            ready     <= 1'b0;
        end else if (!ready) begin
            if (sweep_cnt == BANK_ROWS) begin
                ready <= 1'b1;
            end else begin
                sweep_cnt <= sweep_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        for (int p = 0; p < READ_PORTS; p++) begin
            rd_row[p] = raddr[p].split.row;
        end
    end

    assign wr_row  = sweeping ? sweep_cnt[ROW_WIDTH-1:0] : waddr.split.row;
    assign wr_data = sweeping ? RESET_VALUE : wdata;

    assign bank0.rd_en     = read_enables(1'b0, en, ready, raddr);
    assign bank0.rd_row    = rd_row;
    assign bank0.wr_strobe = write_strobes(1'b0, sweeping, ready, we, waddr);
    assign bank0.wr_row    = wr_row;
    assign bank0.wr_data   = wr_data;

    assign bank1.rd_en     = read_enables(1'b1, en, ready, raddr);
    assign bank1.rd_row    = rd_row;
    assign bank1.wr_strobe = write_strobes(1'b1, sweeping, ready, we, waddr);
    assign bank1.wr_row    = wr_row;
    assign bank1.wr_data   = wr_data;

endmodule

/* design/bank_port_if.sv */
`timescale 1ns/10ps

interface bank_port_if import ram_pkg::*; ();

    logic [READ_PORTS-1:0]  rd_en;
    row_t [READ_PORTS-1:0]  rd_row;
    strobe_t                wr_strobe;    // Zero means no write this cycle
    row_t                   wr_row;
    word_t                  wr_data;
    word_t [READ_PORTS-1:0] rd_data;      // Registered, one cycle after rd_en

    modport access (
        output rd_en,
        output rd_row,
        output wr_strobe,
        output wr_row,
        output wr_data,
        input  rd_data
    );

    modport bank (
        input  rd_en,
        input  rd_row,
        input  wr_strobe,
        input  wr_row,
        input  wr_data,
        output rd_data
    );

endinterface

/* design/mpram_top.sv */
`timescale 1ns/10ps

module mpram_top import ram_pkg::*; #(
    parameter word_t RESET_VALUE = '0
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [READ_PORTS-1:0]      en,
    input  mem_addr_t [READ_PORTS-1:0] raddr,
    input  strobe_t                    we,
    input  mem_addr_t                  waddr,
    input  word_t                      wdata,
    output word_t [READ_PORTS-1:0]     rdata,
    output logic                       ready
);

    bank_port_if bank0_if ();
    bank_port_if bank1_if ();

    // Bank decode, reset sweep and ready
    bank_access #(
        .RESET_VALUE(RESET_VALUE)
    ) u_access (
        .clk   (clk),
        .rst   (rst),
        .en    (en),
        .raddr (raddr),
        .we    (we),
        .waddr (waddr),
        .wdata (wdata),
        .ready (ready),
        .bank0 (bank0_if.access),
        .bank1 (bank1_if.access)
    );

    ram_bank u_bank0 (
        .clk  (clk),
        .rst  (rst),
        .port (bank0_if.bank)
    );

    ram_bank u_bank1 (
        .clk  (clk),
        .rst  (rst),
        .port (bank1_if.bank)
    );

    // Picks each port's data from the bank it addressed
    read_merge u_merge (
        .clk           (clk),
        .rst           (rst),
        .en            (en),
        .raddr         (raddr),
        .ready         (ready),
        .bank0_rd_data (bank0_if.rd_data),
        .bank1_rd_data (bank1_if.rd_data),
        .rdata         (rdata)
    );

endmodule

/* design/ram_bank.sv */
`timescale 1ns/10ps

module ram_bank import ram_pkg::*; (
    input logic       clk,
    input logic       rst,
    bank_port_if.bank port
);

    word_t mem [BANK_ROWS];

    // Byte-lane write, old contents stay visible to reads at this edge
    always_ff @(posedge clk) begin
        for (int j = 0; j < BYTES; j++) begin
            if (port.wr_strobe[j]) begin
                mem[port.wr_row][j] <= port.wr_data[j];
            end
        end
    end

    // Read registers hold their value until the next enabled read
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            port.rd_data <= '0;
        end else begin
            for (int p = 0; p < READ_PORTS; p++) begin
                if (port.rd_en[p]) begin
                    port.rd_data[p] <= mem[port.rd_row[p]];
                end
            end
        end
    end

endmodule

/* design/ram_pkg.sv */
package ram_pkg;

    localparam int DATA_WIDTH = 32;
    localparam int BYTES      = 4;
    localparam int BANKS      = 2;
    localparam int BANK_ROWS  = 8;
    localparam int ROW_WIDTH  = $clog2(BANK_ROWS);
    localparam int BANK_WIDTH = $clog2(BANKS);
    localparam int ADDR_WIDTH = BANK_WIDTH + ROW_WIDTH;
    localparam int READ_PORTS = 2;

    // One word split into byte lanes
    typedef logic [BYTES-1:0][DATA_WIDTH/BYTES-1:0] word_t;

    typedef logic [BYTES-1:0] strobe_t;      // Byte write enables
    typedef logic [ROW_WIDTH-1:0] row_t;

    typedef struct packed {
        logic [BANK_WIDTH-1:0] bank;         // Upper bits pick the bank
        row_t                  row;
    } mem_addr_split_t;

    // Same address seen either whole or as bank and row
    typedef union packed {
        logic [ADDR_WIDTH-1:0] flat;
        mem_addr_split_t       split;
    } mem_addr_t;

endpackage

/* design/read_merge.sv */
`timescale 1ns/10ps

module read_merge import ram_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [READ_PORTS-1:0]      en,
    input  mem_addr_t [READ_PORTS-1:0] raddr,
    input  logic                       ready,
    input  word_t [READ_PORTS-1:0]     bank0_rd_data,
    input  word_t [READ_PORTS-1:0]     bank1_rd_data,
    output word_t [READ_PORTS-1:0]     rdata
);

    logic [READ_PORTS-1:0]                  accept;
    logic [READ_PORTS-1:0][BANK_WIDTH-1:0]  rd_bank;   // Bank of the read in flight
    word_t [BANKS-1:0][READ_PORTS-1:0]      bank_rd;

    assign accept     = en & {READ_PORTS{ready}};
    assign bank_rd[0] = bank0_rd_data;
    assign bank_rd[1] = bank1_rd_data;

    // Loads with the read itself so the select lines up with the data
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rd_bank <= '0;
        end else begin
            for (int p = 0; p < READ_PORTS; p++) begin
                if (accept[p]) begin
                    rd_bank[p] <= raddr[p].split.bank;
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < READ_PORTS; p++) begin
            rdata[p] = bank_rd[rd_bank[p]][p];
        end
    end

endmodule

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module mpram_tb -f build.f -o mpram_sim \
    && ./obj_dir/mpram_sim > sim.log 2>&1 \
    && cat sim.log \
    && ! grep -q "Testbench failed" sim.log \
    || { cat sim.log 2>/dev/null; exit 1; }

/* test/mpram_checker.sv */
`timescale 1ns/10ps

module mpram_checker import ram_pkg::*; #(
    parameter word_t RESET_VALUE = '0
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [READ_PORTS-1:0]      en,
    input  mem_addr_t [READ_PORTS-1:0] raddr,
    input  strobe_t                    we,
    input  mem_addr_t                  waddr,
    input  word_t                      wdata,
    input  word_t [READ_PORTS-1:0]     rdata,
    input  logic                       ready,
    input  logic [127:0]               test_name,
    input  logic                       test_valid,
    input  word_t [READ_PORTS-1:0]     test_exp,
    output int                         error_count
);

    word_t                  model [2**ADDR_WIDTH];
    word_t [READ_PORTS-1:0] model_rd = '0;     // What each port should show now
    word_t [READ_PORTS-1:0] pend_exp = '0;
    logic [127:0]           pend_name = '0;
    logic                   pend = 1'b0;       // A test went in at the last edge
    logic                   bad;
    int                     tests = 0;
    int                     failed = 0;

    assign error_count = failed;

    initial begin
        for (int a = 0; a < 2**ADDR_WIDTH; a++) begin
            model[a] = RESET_VALUE;
        end
    end

    // Reads capture the old word before the write lands
    always @(posedge clk) begin
        pend = 1'b0;
        if (!rst) begin
            model_rd = '0;
        end else if (ready) begin
            for (int p = 0; p < READ_PORTS; p++) begin
                if (en[p]) begin
                    model_rd[p] = model[raddr[p].flat];
                end
            end
            for (int j = 0; j < BYTES; j++) begin
                if (we[j]) begin
                    model[waddr.flat][j] = wdata[j];
                end
            end
            if (test_valid) begin
                pend      = 1'b1;
                pend_name = test_name;
                pend_exp  = test_exp;
            end
        end
    end

    always @(negedge clk) begin
        if (pend) begin
            bad = 1'b0;
            tests++;
            for (int p = 0; p < READ_PORTS; p++) begin
                if (rdata[p] !== model_rd[p]) begin
                    $display("Error: test %0d %0s port %0d expected %h actual %h",
                             tests, pend_name, p, model_rd[p], rdata[p]);
                    bad = 1'b1;
                end else if (rdata[p] !== pend_exp[p]) begin
                    $display("Error: test %0d %0s port %0d table expected %h actual %h",
                             tests, pend_name, p, pend_exp[p], rdata[p]);
                    bad = 1'b1;
                end
            end
            if (bad) begin
                failed++;
            end else begin
                $display("ok    test %0d %0s", tests, pend_name);
            end
        end
    end

    task print_counts();
        $display("Checker: %0d tests run, %0d passed, %0d failed",
                 tests, tests - failed, failed);
    endtask

endmodule

/* test/mpram_properties.sv */
`timescale 1ns/10ps

module mpram_properties import ram_pkg::*; (
    input logic                   clk,
    input logic                   rst,
    input logic [READ_PORTS-1:0]  en,
    input word_t [READ_PORTS-1:0] rdata,
    input logic                   ready
);

    int fail_count = 0;    // Assertion failures so far

    // Sweep runs once, so ready stays up
    ready_held: assert property (@(posedge clk) disable iff (!rst) ready |=> ready)
        else begin
            $error("ready fell after it had risen");
            fail_count++;
        end

    rdata_zero_before_ready: assert property (
        @(posedge clk) disable iff (!rst) !ready |-> rdata == '0
    ) else begin
        $error("rdata is nonzero before ready");
        fail_count++;
    end

    for (genvar p = 0; p < READ_PORTS; p++) begin : g_port
        rdata_held: assert property (
            @(posedge clk) disable iff (!rst) !en[p] |=> $stable(rdata[p])
        ) else begin
            $error("rdata[%0d] changed without a read", p);
            fail_count++;
        end
    end

endmodule

bind mpram_top mpram_properties props0 (
    .clk   (clk),
    .rst   (rst),
    .en    (en),
    .rdata (rdata),
    .ready (ready)
);

/* test/mpram_tb.sv */
`timescale 1ns/10ps

module mpram_tb import ram_pkg::*; ();

    localparam int    NUM_TESTS      = 28;
    localparam int    TIMEOUT_CYCLES = 50;
    localparam word_t RESET_VALUE    = 32'hA5C3_0F96;

    logic                       clk;
    logic                       rst;
    logic [READ_PORTS-1:0]      en;
    mem_addr_t [READ_PORTS-1:0] raddr;
    strobe_t                    we;
    mem_addr_t                  waddr;
    word_t                      wdata;
    word_t [READ_PORTS-1:0]     rdata;
    logic                       ready;
    logic [127:0]               test_name;
    logic                       test_valid;
    word_t [READ_PORTS-1:0]     test_exp;
    int                         error_count;

    // Stimulus with the words each port should show one cycle later
    logic [127:0]               name_tab  [NUM_TESTS];
    strobe_t                    we_tab    [NUM_TESTS];
    mem_addr_t                  waddr_tab [NUM_TESTS];
    word_t                      wdata_tab [NUM_TESTS];
    logic [READ_PORTS-1:0]      en_tab    [NUM_TESTS];
    mem_addr_t [READ_PORTS-1:0] raddr_tab [NUM_TESTS];
    word_t [READ_PORTS-1:0]     exp_tab   [NUM_TESTS];

    int                         seed = 55;
    int                         n_entries;
    int                         wait_cycles;
    logic                       timed_out;

    mpram_top #(
        .RESET_VALUE(RESET_VALUE)
    ) dut0 (
        .clk   (clk),
        .rst   (rst),
        .en    (en),
        .raddr (raddr),
        .we    (we),
        .waddr (waddr),
        .wdata (wdata),
        .rdata (rdata),
        .ready (ready)
    );

    mpram_checker #(
        .RESET_VALUE(RESET_VALUE)
    ) chk0 (
        .clk         (clk),
        .rst         (rst),
        .en          (en),
        .raddr       (raddr),
        .we          (we),
        .waddr       (waddr),
        .wdata       (wdata),
        .rdata       (rdata),
        .ready       (ready),
        .test_name   (test_name),
        .test_valid  (test_valid),
        .test_exp    (test_exp),
        .error_count (error_count)
    );

    function automatic word_t lane_merge(input word_t old_word, input word_t new_word,
                                         input strobe_t mask);
        word_t merged;
        merged = old_word;
        for (int j = 0; j < BYTES; j++) begin
            if (mask[j]) begin
                merged[j] = new_word[j];
            end
        end
        return merged;
    endfunction

    task automatic add_entry(input logic [127:0] name, input strobe_t wr_en,
                             input logic [ADDR_WIDTH-1:0] wa, input word_t wd,
                             input logic [READ_PORTS-1:0] rd_en,
                             input logic [ADDR_WIDTH-1:0] ra0, input logic [ADDR_WIDTH-1:0] ra1,
                             input word_t exp0, input word_t exp1);
        name_tab[n_entries]          = name;
        we_tab[n_entries]            = wr_en;
        waddr_tab[n_entries].flat    = wa;
        wdata_tab[n_entries]         = wd;
        en_tab[n_entries]            = rd_en;
        raddr_tab[n_entries][0].flat = ra0;
        raddr_tab[n_entries][1].flat = ra1;
        exp_tab[n_entries][0]        = exp0;
        exp_tab[n_entries][1]        = exp1;
        n_entries++;
    endtask

    task automatic fill_table();
        word_t w1;
        word_t w2;
        word_t w3;
        word_t w4;
        word_t w5;
        word_t part;
        word_t rv;
        w1   = $random(seed);
        w2   = $random(seed);
        w3   = $random(seed);
        w4   = $random(seed);
        w5   = $random(seed);
        part = lane_merge(w1, w2, 4'b0101);
        rv   = RESET_VALUE;
        n_entries = 0;
        for (int a = 0; a < 2**ADDR_WIDTH; a++) begin
            add_entry("init_read", 4'h0, 4'h0, '0, 2'b11, a[3:0], 4'(15 - a), rv, rv);
        end
        add_entry("wr_bank1",      4'hF, 4'hB, w1, 2'b00, 4'h0, 4'h0, rv, rv);
        add_entry("rd_bank1",      4'h0, 4'h0, '0, 2'b11, 4'hB, 4'h3, w1, rv);
        add_entry("wr_partial",    4'h5, 4'hB, w2, 2'b00, 4'h0, 4'h0, w1, rv);
        add_entry("rd_partial",    4'h0, 4'h0, '0, 2'b01, 4'hB, 4'h0, part, rv);
        add_entry("rw_same",       4'hF, 4'h5, w3, 2'b01, 4'h5, 4'h0, rv, rv);
        add_entry("rd_after",      4'h0, 4'h0, '0, 2'b10, 4'h0, 4'h5, rv, w3);
        add_entry("wr_b0_row2",    4'hF, 4'h2, w4, 2'b00, 4'h0, 4'h0, rv, w3);
        add_entry("wr_b1_row2",    4'hF, 4'hA, w5, 2'b00, 4'h0, 4'h0, rv, w3);
        add_entry("rd_both_banks", 4'h0, 4'h0, '0, 2'b11, 4'hA, 4'h2, w5, w4);
        add_entry("rd_swap",       4'h0, 4'h0, '0, 2'b11, 4'h2, 4'hA, w4, w5);
        add_entry("hold_both",     4'h0, 4'h0, '0, 2'b00, 4'h0, 4'h0, w4, w5);
        add_entry("hold_port1",    4'h0, 4'h0, '0, 2'b01, 4'hB, 4'h5, part, w5);
    endtask

    task automatic drive_entry(input int i);
        test_name  = name_tab[i];
        test_valid = 1'b1;
        test_exp   = exp_tab[i];
        we         = we_tab[i];
        waddr      = waddr_tab[i];
        wdata      = wdata_tab[i];
        en         = en_tab[i];
        raddr      = raddr_tab[i];
    endtask

    task automatic drive_idle();
        test_name  = '0;
        test_valid = 1'b0;
        test_exp   = '0;
        we         = '0;
        waddr      = '0;
        wdata      = '0;
        en         = '0;
        raddr      = '0;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst         = 1'b0;
        timed_out   = 1'b0;
        wait_cycles = 0;
        drive_idle();
        fill_table();
        repeat (5) @(negedge clk);
        rst = 1'b1;
        while (!ready && wait_cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (!ready) begin
            $display("Timeout: ready never rose within %0d cycles of reset", TIMEOUT_CYCLES);
            timed_out = 1'b1;
        end else begin
            for (int i = 0; i < NUM_TESTS; i++) begin
                drive_entry(i);
                @(negedge clk);
            end
            drive_idle();
            @(negedge clk);                          // Checker finishes the last compare first
        end
        chk0.print_counts();
        if (timed_out || error_count != 0 || dut0.props0.fail_count != 0) begin
            $display("Testbench failed");
        end else begin
            $display("Testbench passed");
        end
        $finish;
    end

endmodule
